// File: tlbMissPkg.sv
`default_nettype none

package tlbMissPkg;

    localparam int SQN_LEN = 7;
    localparam int VPN_LEN = 20;
    localparam int PPN_LEN = 20;
    localparam int OFFS_LEN = 12;

    typedef struct packed {
        logic [31:0] addr;
        logic [SQN_LEN-1:0] sqN;
        logic isStore;
        logic valid;
    } AguUop;

    typedef struct packed {
        logic [31:0] paddr;
        logic [SQN_LEN-1:0] sqN;
        logic isStore;
        logic valid;
    } PhysUop;

    typedef struct packed {
        logic taken;
        logic [SQN_LEN-1:0] sqN;
    } BranchProv;

    typedef struct packed {
        logic sv32en;
        logic [PPN_LEN-1:0] rootPpn;
    } VirtMemState;

    typedef struct packed {
        logic valid;
        logic [VPN_LEN-1:0] vpn;
        logic [PPN_LEN-1:0] ppn;
        logic isSuperPage;
    } PageWalkRes;

    typedef struct packed {
        logic valid;
        logic [31:0] addr;
    } PteReq;

    typedef struct packed {
        logic valid;
        logic [31:0] pte;
    } PteResp;

    // True when a is younger than b across sequence number wraparound
    function automatic logic isYounger(input logic [SQN_LEN-1:0] a,
                                       input logic [SQN_LEN-1:0] b);
        logic [SQN_LEN-1:0] diff;
        diff = a - b;
        return $signed(diff) > 0;
    endfunction

    // Superpages only compare the upper VPN half
    function automatic logic pageMatch(input logic [VPN_LEN-1:0] a,
                                       input logic [VPN_LEN-1:0] b,
                                       input logic isSuper);
        if (isSuper)
            return a[VPN_LEN-1:VPN_LEN/2] == b[VPN_LEN-1:VPN_LEN/2];
        return a == b;
    endfunction

endpackage

`default_nettype wire

// File: tlbCache.sv
`timescale 1ns/1ps
`default_nettype none

module tlbCache #(
    parameter int TLB_ENTRIES = 4
) (
    input  wire                              clk,
    input  wire                              rst,
    input  wire [tlbMissPkg::VPN_LEN-1:0]    lookupVpn,
    output logic                             hit,
    output logic [tlbMissPkg::PPN_LEN-1:0]   hitPpn,
    output logic                             hitSuper,
    input  tlbMissPkg::PageWalkRes           pwRes
);

    localparam int IDX_LEN = TLB_ENTRIES > 1 ? $clog2(TLB_ENTRIES) : 1;

    logic [TLB_ENTRIES-1:0] valid;
    logic [tlbMissPkg::VPN_LEN-1:0] vpns [TLB_ENTRIES];
    logic [tlbMissPkg::PPN_LEN-1:0] ppns [TLB_ENTRIES];
    logic [TLB_ENTRIES-1:0] supers;

    logic [IDX_LEN-1:0] victim;
    logic [IDX_LEN-1:0] freeIdx;
    logic freeFound;
    logic [IDX_LEN-1:0] fillIdx;

    always_comb begin
        hit = 1'b0;
        hitPpn = '0;
        hitSuper = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (valid[i] && tlbMissPkg::pageMatch(vpns[i], lookupVpn, supers[i])) begin
                hit = 1'b1;
                hitPpn = ppns[i];
                hitSuper = supers[i];
            end
        end
    end

    // Empty entries are filled before anything is evicted
    always_comb begin
        freeIdx = '0;
        freeFound = 1'b0;
        for (int i = 0; i < TLB_ENTRIES; i++) begin
            if (!freeFound && !valid[i]) begin
                freeIdx = IDX_LEN'(i);
                freeFound = 1'b1;
            end
        end
    end

    assign fillIdx = freeFound ? freeIdx : victim;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
            victim <= '0;
        end else if (pwRes.valid) begin
            valid[fillIdx] <= 1'b1;
            vpns[fillIdx] <= pwRes.vpn;
            ppns[fillIdx] <= pwRes.ppn;
            supers[fillIdx] <= pwRes.isSuperPage;
            if (!freeFound) begin
                if (victim == IDX_LEN'(TLB_ENTRIES - 1))
                    victim <= '0;
                else
                    victim <= victim + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: tlbMissQueue.sv
`timescale 1ns/1ps
`default_nettype none

module tlbMissQueue #(
    parameter int QUEUE_SIZE = 4
) (
    input  wire                      clk,
    input  wire                      rst,
    input  tlbMissPkg::BranchProv    branch,
    input  tlbMissPkg::VirtMemState  vmem,
    input  tlbMissPkg::PageWalkRes   pwRes,
    input  wire                      pwActive,
    output logic                     stall,
    input  wire                      enqueue,
    input  wire                      uopReady,
    input  tlbMissPkg::AguUop        uop,
    input  wire                      dequeue,
    output tlbMissPkg::AguUop        replay
);

    localparam int IDX_LEN = $clog2(QUEUE_SIZE);

    tlbMissPkg::AguUop entries [QUEUE_SIZE];
    logic [QUEUE_SIZE-1:0] ready;

    logic [IDX_LEN-1:0] freeIdx;
    logic freeValid;
    logic [IDX_LEN:0] freeCnt;

    logic [IDX_LEN-1:0] outIdx;
    logic outValid;

    logic enqKilled;
    logic replayKilled;

    // Lowest free slot and number of free slots
    always_comb begin
        freeIdx = '0;
        freeValid = 1'b0;
        freeCnt = '0;
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            if (!entries[i].valid) begin
                freeCnt = freeCnt + 1'b1;
                if (!freeValid) begin
                    freeIdx = IDX_LEN'(i);
                    freeValid = 1'b1;
                end
            end
        end
    end

    // Stage must always have room for the op it holds
    assign stall = freeCnt < (IDX_LEN+1)'(2);

    // Non-ready ops go out too while the walker is idle, so their miss starts a walk
    always_comb begin
        outIdx = '0;
        outValid = 1'b0;
        for (int i = 0; i < QUEUE_SIZE; i++) begin
            if (!outValid && entries[i].valid && (ready[i] || !pwActive)) begin
                outIdx = IDX_LEN'(i);
                outValid = 1'b1;
            end
        end
    end

    assign enqKilled = branch.taken && tlbMissPkg::isYounger(uop.sqN, branch.sqN);
    assign replayKilled = branch.taken && tlbMissPkg::isYounger(replay.sqN, branch.sqN);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < QUEUE_SIZE; i++) begin
                entries[i].valid <= 1'b0;
            end
            ready <= '0;
            replay.valid <= 1'b0;
        end else begin
            // Walk result wakes up every op on that page
            if (pwRes.valid) begin
                for (int i = 0; i < QUEUE_SIZE; i++) begin
                    if (entries[i].valid && tlbMissPkg::pageMatch(pwRes.vpn,
                            entries[i].addr[31:12], pwRes.isSuperPage)) begin
                        ready[i] <= 1'b1;
                    end
                end
            end

            if (branch.taken) begin
                for (int i = 0; i < QUEUE_SIZE; i++) begin
                    if (entries[i].valid &&
                            tlbMissPkg::isYounger(entries[i].sqN, branch.sqN)) begin
                        entries[i].valid <= 1'b0;
                        ready[i] <= 1'b0;
                    end
                end
            end

            if (enqueue && uop.valid && !enqKilled) begin
                entries[freeIdx] <= uop;
                ready[freeIdx] <= !vmem.sv32en || uopReady;
            end

            if (dequeue || replayKilled) begin
                replay.valid <= 1'b0;
            end

            // Refill the replay register
            if ((!replay.valid || dequeue) && outValid) begin
                if (!(branch.taken &&
                        tlbMissPkg::isYounger(entries[outIdx].sqN, branch.sqN))) begin
                    replay <= entries[outIdx];
                    entries[outIdx].valid <= 1'b0;
                    ready[outIdx] <= 1'b0;
                end
            end
        end
    end

    // Stage holds back new ops early enough that a miss never finds the queue full
    enqueueHasSlot: assert property (@(posedge clk) disable iff (rst)
        enqueue |-> freeValid);

    dequeueOnlyValid: assert property (@(posedge clk) disable iff (rst)
        dequeue |-> replay.valid);

endmodule

`default_nettype wire

// File: pageWalker.sv
`timescale 1ns/1ps
`default_nettype none

module pageWalker (
    input  wire                                  clk,
    input  wire                                  rst,
    input  tlbMissPkg::VirtMemState              vmem,
    input  wire                                  walkStart,
    input  wire [tlbMissPkg::VPN_LEN-1:0]        walkVpn,
    output tlbMissPkg::PteReq                    pteReq,
    input  tlbMissPkg::PteResp                   pteResp,
    output logic                                 pwActive,
    output tlbMissPkg::PageWalkRes               pwRes
);

    // PTE permission bits
    localparam int PTE_R = 1;
    localparam int PTE_X = 3;

    typedef enum logic [1:0] {
        WalkIdle,
        WalkRoot,
        WalkLeaf
    } WalkState;

    WalkState state;
    logic [tlbMissPkg::VPN_LEN-1:0] vpn;
    logic isLeaf;

    assign pwActive = state != WalkIdle;
    assign isLeaf = pteResp.pte[PTE_R] || pteResp.pte[PTE_X];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= WalkIdle;
            pteReq.valid <= 1'b0;
            pwRes.valid <= 1'b0;
        end else begin
            pteReq.valid <= 1'b0;
            pwRes.valid <= 1'b0;
            case (state)
                WalkIdle: begin
                    if (walkStart) begin
                        vpn <= walkVpn;
                        pteReq.valid <= 1'b1;
                        pteReq.addr <= {vmem.rootPpn, walkVpn[19:10], 2'b00};
                        state <= WalkRoot;
                    end
                end
                WalkRoot: begin
                    if (pteResp.valid) begin
                        if (isLeaf) begin
                            // Leaf at level one maps a 4 MiB region
                            pwRes.valid <= 1'b1;
                            pwRes.vpn <= vpn;
                            pwRes.ppn <= pteResp.pte[29:10];
                            pwRes.isSuperPage <= 1'b1;
                            state <= WalkIdle;
                        end else begin
                            pteReq.valid <= 1'b1;
                            pteReq.addr <= {pteResp.pte[29:10], vpn[9:0], 2'b00};
                            state <= WalkLeaf;
                        end
                    end
                end
                WalkLeaf: begin
                    if (pteResp.valid) begin
                        pwRes.valid <= 1'b1;
                        pwRes.vpn <= vpn;
                        pwRes.ppn <= pteResp.pte[29:10];
                        pwRes.isSuperPage <= 1'b0;
                        state <= WalkIdle;
                    end
                end
                default: state <= WalkIdle;
            endcase
        end
    end

    // Stage only starts a walk while the walker is idle
    noStartWhileBusy: assert property (@(posedge clk) disable iff (rst)
        walkStart |-> !pwActive);

endmodule

`default_nettype wire

// File: aguTlbStage.sv
`timescale 1ns/1ps
`default_nettype none

module aguTlbStage (
    input  wire                              clk,
    input  wire                              rst,
    input  tlbMissPkg::BranchProv            branch,
    input  tlbMissPkg::VirtMemState          vmem,
    input  tlbMissPkg::AguUop                uop,
    output logic                             stall,
    input  wire                              queueStall,
    input  tlbMissPkg::AguUop                replay,
    output logic                             dequeue,
    output logic [tlbMissPkg::VPN_LEN-1:0]   lookupVpn,
    input  wire                              hit,
    input  wire [tlbMissPkg::PPN_LEN-1:0]    hitPpn,
    input  wire                              hitSuper,
    output logic                             enqueue,
    output logic                             uopReady,
    output tlbMissPkg::AguUop                missUop,
    input  tlbMissPkg::PageWalkRes           pwRes,
    input  wire                              pwActive,
    output logic                             walkStart,
    output logic [tlbMissPkg::VPN_LEN-1:0]   walkVpn,
    output tlbMissPkg::PhysUop               result
);

    tlbMissPkg::AguUop sel;
    logic isReplay;
    logic accept;
    logic translated;
    logic [31:0] paddr;

    // Replays win over new ops
    always_comb begin
        isReplay = replay.valid;
        sel = replay;
        if (!isReplay) begin
            sel = uop;
            sel.valid = uop.valid && !queueStall;
        end
    end

    assign stall = queueStall || replay.valid;
    assign dequeue = replay.valid;

    assign accept = sel.valid &&
        !(branch.taken && tlbMissPkg::isYounger(sel.sqN, branch.sqN));
    assign lookupVpn = sel.addr[31:12];
    assign translated = !vmem.sv32en || hit;

    always_comb begin
        if (!vmem.sv32en)
            paddr = sel.addr;
        else if (hitSuper)
            paddr = {hitPpn[19:10], sel.addr[21:0]};
        else
            paddr = {hitPpn, sel.addr[tlbMissPkg::OFFS_LEN-1:0]};
    end

    // A walk finishing for this page right now means the op is ready on arrival
    assign uopReady = pwRes.valid &&
        tlbMissPkg::pageMatch(pwRes.vpn, sel.addr[31:12], pwRes.isSuperPage);

    assign enqueue = accept && !translated;
    assign missUop = sel;

    assign walkStart = enqueue && isReplay && !pwActive && !uopReady;
    assign walkVpn = sel.addr[31:12];

    always_ff @(posedge clk) begin
        if (rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= accept && translated;
            result.paddr <= paddr;
            result.sqN <= sel.sqN;
            result.isStore <= sel.isStore;
        end
    end

endmodule

`default_nettype wire

// File: tlbMissTop.sv
`timescale 1ns/1ps
`default_nettype none

module tlbMissTop #(
    parameter int QUEUE_SIZE = 4,
    parameter int TLB_ENTRIES = 4
) (
    input  wire                      clk,
    input  wire                      rst,
    input  tlbMissPkg::BranchProv    branch,
    input  tlbMissPkg::VirtMemState  vmem,
    input  tlbMissPkg::AguUop        uop,
    output logic                     stall,
    output tlbMissPkg::PteReq        pteReq,
    input  tlbMissPkg::PteResp       pteResp,
    output tlbMissPkg::PhysUop       result
);

    logic queueStall;
    logic dequeue;
    logic enqueue;
    logic uopReady;
    tlbMissPkg::AguUop replay;
    tlbMissPkg::AguUop missUop;

    logic [tlbMissPkg::VPN_LEN-1:0] lookupVpn;
    logic hit;
    logic [tlbMissPkg::PPN_LEN-1:0] hitPpn;
    logic hitSuper;

    logic walkStart;
    logic [tlbMissPkg::VPN_LEN-1:0] walkVpn;
    logic pwActive;
    tlbMissPkg::PageWalkRes pwRes;

    aguTlbStage stage_i (
        .clk        (clk),
        .rst        (rst),
        .branch     (branch),
        .vmem       (vmem),
        .uop        (uop),
        .stall      (stall),
        .queueStall (queueStall),
        .replay     (replay),
        .dequeue    (dequeue),
        .lookupVpn  (lookupVpn),
        .hit        (hit),
        .hitPpn     (hitPpn),
        .hitSuper   (hitSuper),
        .enqueue    (enqueue),
        .uopReady   (uopReady),
        .missUop    (missUop),
        .pwRes      (pwRes),
        .pwActive   (pwActive),
        .walkStart  (walkStart),
        .walkVpn    (walkVpn),
        .result     (result)
    );

    tlbCache #(.TLB_ENTRIES(TLB_ENTRIES)) tlb_i (
        .clk       (clk),
        .rst       (rst),
        .lookupVpn (lookupVpn),
        .hit       (hit),
        .hitPpn    (hitPpn),
        .hitSuper  (hitSuper),
        .pwRes     (pwRes)
    );

    tlbMissQueue #(.QUEUE_SIZE(QUEUE_SIZE)) queue_i (
        .clk      (clk),
        .rst      (rst),
        .branch   (branch),
        .vmem     (vmem),
        .pwRes    (pwRes),
        .pwActive (pwActive),
        .stall    (queueStall),
        .enqueue  (enqueue),
        .uopReady (uopReady),
        .uop      (missUop),
        .dequeue  (dequeue),
        .replay   (replay)
    );

    pageWalker walker_i (
        .clk       (clk),
        .rst       (rst),
        .vmem      (vmem),
        .walkStart (walkStart),
        .walkVpn   (walkVpn),
        .pteReq    (pteReq),
        .pteResp   (pteResp),
        .pwActive  (pwActive),
        .pwRes     (pwRes)
    );

endmodule

`default_nettype wire

// File: tlbMissTb.sv
`timescale 1ns/1ps
`default_nettype none

module tlbMissTb;

    localparam int QUEUE_SIZE = 4;
    localparam int TLB_ENTRIES = 4;
    localparam int STALL_LIMIT = 200;
    localparam int DRAIN_LIMIT = 400;

    logic clk;
    logic rst;
    tlbMissPkg::BranchProv branch;
    tlbMissPkg::VirtMemState vmem;
    tlbMissPkg::AguUop uop;
    logic stall;
    tlbMissPkg::PteReq pteReq;
    tlbMissPkg::PteResp pteResp;
    tlbMissPkg::PhysUop result;

    logic [31:0] pageTable [logic [31:0]];
    tlbMissPkg::PhysUop expected [int];
    int expCycle [int];
    logic [31:0] pendingPte [$];
    logic [20:0] resident [$];

    int cycleCnt = 0;
    int valueErrors = 0;
    int otherErrors = 0;
    int pteReads = 0;
    int expReads = 0;
    bit timedOut = 0;
    bit stallSeen = 0;
    int latency;
    logic [31:0] reqAddr;

    tlbMissTop #(.QUEUE_SIZE(QUEUE_SIZE), .TLB_ENTRIES(TLB_ENTRIES)) dut_i (
        .clk     (clk),
        .rst     (rst),
        .branch  (branch),
        .vmem    (vmem),
        .uop     (uop),
        .stall   (stall),
        .pteReq  (pteReq),
        .pteResp (pteResp),
        .result  (result)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    function automatic logic [31:0] readPte(input logic [31:0] addr);
        if (pageTable.exists(addr))
            return pageTable[addr];
        return 32'h0;
    endfunction

    // Sv32 translation straight from the page table
    function automatic logic [31:0] modelPaddr(input logic [31:0] va);
        logic [31:0] pte1;
        logic [31:0] pte2;
        if (!vmem.sv32en)
            return va;
        pte1 = readPte({vmem.rootPpn, va[31:22], 2'b00});
        if (pte1[1] || pte1[3])
            return {pte1[29:20], va[21:0]};
        pte2 = readPte({pte1[29:10], va[21:12], 2'b00});
        return {pte2[29:10], va[11:0]};
    endfunction

    // Walks the model TLB needs, with FIFO eviction like in-order fills
    task automatic noteWalk(input logic [31:0] va);
        logic [31:0] addr1;
        logic [31:0] pte1;
        logic [20:0] key;
        bit isSuper;
        addr1 = {vmem.rootPpn, va[31:22], 2'b00};
        pte1 = readPte(addr1);
        isSuper = pte1[1] || pte1[3];
        key = isSuper ? {1'b1, va[31:22], 10'b0} : {1'b0, va[31:12]};
        foreach (resident[i]) begin
            if (resident[i] == key)
                return;
        end
        pendingPte.push_back(addr1);
        expReads++;
        if (!isSuper) begin
            pendingPte.push_back({pte1[29:10], va[21:12], 2'b00});
            expReads++;
        end
        resident.push_back(key);
        if (resident.size() > TLB_ENTRIES)
            void'(resident.pop_front());
    endtask

    task automatic checkPhysUop(input tlbMissPkg::PhysUop got, input tlbMissPkg::PhysUop exp);
        if (got !== exp) begin
            valueErrors++;
            $display("[ERROR] %0t: sqN %0d paddr %h store %b, expected paddr %h store %b",
                     $time, got.sqN, got.paddr, got.isStore, exp.paddr, exp.isStore);
        end
    endtask

    task automatic checkPteAddr(input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            valueErrors++;
            $display("[ERROR] %0t: PTE read at %h, expected %h", $time, got, exp);
        end
    endtask

    task automatic checkStall(input logic got, input logic exp);
        if (got !== exp) begin
            valueErrors++;
            $display("[ERROR] %0t: stall %b, expected %b", $time, got, exp);
        end
    endtask

    // Walks may run in any order, so match against any pending read
    task automatic matchPteRead(input logic [31:0] addr);
        logic [31:0] exp;
        int idx;
        idx = -1;
        foreach (pendingPte[i]) begin
            if (idx < 0 && pendingPte[i] == addr)
                idx = i;
        end
        if (idx >= 0) begin
            exp = pendingPte[idx];
            pendingPte.delete(idx);
        end else begin
            exp = pendingPte.size() > 0 ? pendingPte[0] : 32'hffff_ffff;
        end
        checkPteAddr(addr, exp);
    endtask

    // PTE memory with random latency
    always @(negedge clk) begin
        if (!rst && pteReq.valid) begin
            reqAddr = pteReq.addr;
            pteReads++;
            matchPteRead(reqAddr);
            latency = 1 + ($urandom % 4);
            repeat (latency) @(posedge clk);
            #1;
            pteResp.pte = readPte(reqAddr);
            pteResp.valid = 1'b1;
            @(posedge clk);
            #1;
            pteResp.valid = 1'b0;
        end
    end

    // A queued miss only returns through a replay, which holds stall high
    always @(negedge clk) begin
        if (!rst && stall)
            stallSeen = 1'b1;
    end

    always @(negedge clk) begin
        if (!rst && result.valid) begin
            if (expected.exists(int'(result.sqN))) begin
                checkPhysUop(result, expected[int'(result.sqN)]);
                if (expCycle.exists(int'(result.sqN)) &&
                        expCycle[int'(result.sqN)] != cycleCnt) begin
                    valueErrors++;
                    $display("[ERROR] %0t: sqN %0d came in cycle %0d, expected cycle %0d",
                             $time, result.sqN, cycleCnt, expCycle[int'(result.sqN)]);
                end
                expected.delete(int'(result.sqN));
                expCycle.delete(int'(result.sqN));
            end else begin
                otherErrors++;
                $display("Result for sqN %0d was not expected (killed or duplicate)",
                         result.sqN);
            end
        end
    end

    task automatic waitStallLow();
        int n;
        n = 0;
        while (stall && n < STALL_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (stall) begin
            $display("Timeout: stall stayed high for %0d cycles", STALL_LIMIT);
            timedOut = 1;
        end
    endtask

    task automatic drainScoreboard();
        int n;
        n = 0;
        while (expected.size() != 0 && n < DRAIN_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (expected.size() != 0) begin
            $display("Timeout: %0d micro-ops never completed", expected.size());
            timedOut = 1;
        end
    endtask

    task automatic presentUop(input logic [31:0] addr, input int sq, input int st);
        tlbMissPkg::PhysUop exp;
        waitStallLow();
        if (timedOut)
            return;
        exp.paddr = modelPaddr(addr);
        exp.sqN = tlbMissPkg::SQN_LEN'(sq);
        exp.isStore = st[0];
        exp.valid = 1'b1;
        expected[sq] = exp;
        if (vmem.sv32en)
            noteWalk(addr);
        else
            expCycle[sq] = cycleCnt + 1;
        uop.addr = addr;
        uop.sqN = tlbMissPkg::SQN_LEN'(sq);
        uop.isStore = st[0];
        uop.valid = 1'b1;
        @(posedge clk);
        #1;
        uop.valid = 1'b0;
    endtask

    function automatic bit olderThan(input int b, input int a);
        logic [tlbMissPkg::SQN_LEN-1:0] diff;
        diff = tlbMissPkg::SQN_LEN'(a - b);
        return $signed(diff) > 0;
    endfunction

    task automatic applyBranch(input int sq);
        int killed [$];
        branch.taken = 1'b1;
        branch.sqN = tlbMissPkg::SQN_LEN'(sq);
        foreach (expected[k]) begin
            if (olderThan(sq, k))
                killed.push_back(k);
        end
        foreach (killed[i]) begin
            expected.delete(killed[i]);
            expCycle.delete(killed[i]);
        end
        @(posedge clk);
        #1;
        branch.taken = 1'b0;
    endtask

    initial begin
        int fd;
        int rc;
        byte kind;
        string skipLine;
        logic [31:0] a;
        logic [31:0] b;
        int s;
        int st;
        rst = 1'b1;
        branch = '0;
        vmem = '0;
        uop = '0;
        pteResp = '0;
        void'($urandom(83));
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        fd = $fopen("tlbMissCases.txt", "r");
        if (fd == 0) begin
            otherErrors++;
            $display("Could not open tlbMissCases.txt");
        end else begin
            while (!timedOut && $fscanf(fd, " %c", kind) == 1) begin
                case (kind)
                    "#": rc = $fgets(skipLine, fd);
                    "M": begin
                        rc = $fscanf(fd, "%h %h", a, b);
                        vmem.sv32en = a[0];
                        vmem.rootPpn = b[19:0];
                    end
                    "P": begin
                        rc = $fscanf(fd, "%h %h", a, b);
                        pageTable[a] = b;
                    end
                    "U": begin
                        rc = $fscanf(fd, "%h %d %d", a, s, st);
                        presentUop(a, s, st);
                    end
                    "B": begin
                        rc = $fscanf(fd, "%d", s);
                        applyBranch(s);
                    end
                    "W": begin
                        rc = $fscanf(fd, "%d", s);
                        drainScoreboard();
                        repeat (s) @(posedge clk);
                        #1;
                    end
                    default: begin
                        otherErrors++;
                        $display("Unknown line kind %c in case file", kind);
                    end
                endcase
            end
            $fclose(fd);
        end
        if (!timedOut)
            drainScoreboard();
        // Nothing is left in the queue once every op has completed
        if (!timedOut)
            checkStall(stall, 1'b0);
        if (!stallSeen) begin
            otherErrors++;
            $display("Stall never went high while misses were queued");
        end
        if (pendingPte.size() != 0) begin
            otherErrors++;
            $display("%0d expected PTE reads never happened", pendingPte.size());
        end
        if (pteReads != expReads) begin
            valueErrors++;
            $display("[ERROR] %0t: %0d PTE reads, expected %0d", $time, pteReads, expReads);
        end
        $display("Value errors: %0d, other errors: %0d, timeout: %0d",
                 valueErrors, otherErrors, timedOut);
        if (valueErrors == 0 && otherErrors == 0 && !timedOut)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

// File: tlbMissCases.txt
# M sv32en rootPpn | P addr pte | U addr sqN isStore | B sqN | W idleCycles
# addr, pte and rootPpn in hex; sqN, isStore and idleCycles in decimal
P 00010004 00008001
P 00010008 2000000F
P 00020004 048D1407
P 00020008 02AF3407
P 0002000C 001DDC07
P 00020010 00266407
P 00020014 002AF007
M 0 00010
U 00001234 1 0
U 00401abc 2 1
U 80000004 3 0
W 3
M 1 00010
U 00401010 4 0
W 2
U 00401ff8 5 1
U 00812345 6 0
W 2
U 00a00010 7 1
W 2
U 00402000 8 0
U 00403004 9 1
U 00402008 10 0
U 00403010 11 0
W 2
U 00404000 20 0
U 00404100 21 0
U 00404200 22 1
B 20
W 4
U 00405000 30 0
U 00405010 31 1
U 00405020 32 0
U 00405030 33 0
U 00405040 34 1
U 00405050 35 0
U 00405060 36 0
W 4
M 0 00010
U 00405abc 40 0
W 2

// File: tlbMiss.f
tlbMissPkg.sv
tlbCache.sv
tlbMissQueue.sv
pageWalker.sv
aguTlbStage.sv
tlbMissTop.sv
tlbMissTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= tlbMissTb
FILELIST ?= tlbMiss.f
PASS_MSG = Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
